// ==== files.f ====
design/nes_bus_pkg.sv
design/nes_clock_divider.sv
design/oam_dmc_dma.sv
design/nes_bus_decoder.sv
design/nes_read_return.sv
design/nes_dma_bus.sv
verif/tb_nes_dma_bus.sv

// ==== verif/tb_nes_dma_bus.sv ====
// ==============================
// NES bus/DMA core testbench
// Table driven decode and read return checks, sprite DMA with a DMC steal
// ==============================
`timescale 1ns/1ps

module tb_nes_dma_bus;

	logic                             clk;
	logic                             reset;
	nes_bus_pkg::cpu_req_t            cpu;
	logic                             cpu_ce;
	logic [7:0]                       cpu_rdata;
	logic                             pause_cpu;
	logic                             dmc_req;
	logic [15:0]                      dmc_addr;
	logic                             dmc_ack;
	logic [15:0]                      mem_addr;
	logic [7:0]                       mem_wdata;
	logic                             prg_read;
	logic                             prg_write;
	logic                             ppu_read;
	logic                             ppu_write;
	logic [7:0]                       prg_rdata;
	logic [7:0]                       ppu_rdata;
	logic [7:0]                       apu_status;
	logic [2:0]                       joypad_out;
	logic [1:0]                       joypad_clock;
	logic [nes_bus_pkg::joy_bits-1:0] joypad1_data;
	logic [nes_bus_pkg::joy_bits-1:0] joypad2_data;

	// Stimulus table, strobe column is {ppu_write, ppu_read, prg_write, prg_read}
	nes_bus_pkg::cpu_req_t tab_req[16];
	logic [4:0]            tab_joy1[16];
	logic [4:0]            tab_joy2[16];
	logic [3:0]            tab_strobe[16];
	logic [7:0]            tab_rdata[16];
	int                    n_tab = 0;
	logic [7:0]            prev_rdata = 8'h00; // Idle reads of $0000 return 00

	// What one CPU cycle showed
	int                    strobe_cnt[4];
	int                    jclk_cnt[2];
	logic [15:0]           cyc_addr;
	logic [7:0]            cyc_data;
	logic [7:0]            rd_at_ce;
	logic                  pause_at_ce;
	logic                  ack_at_ce;
	nes_bus_pkg::region_t  reg_at_ce;

	string  strobe_name[4] = '{"prg_read", "prg_write", "ppu_read", "ppu_write"};
	integer seed;
	int     cycles = 0;
	int     limit;
	int     errors = 0;
	int     tests = 0;
	int     failed_tests = 0;
	logic   test_failed;

	nes_dma_bus nes_dma_bus_i (.*);

	assign prg_rdata = mem_addr[7:0] ^ mem_addr[15:8]; // Memory model
	assign ppu_rdata = ~mem_addr[7:0];

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > limit) begin
			$display("timeout: no result after %0d clocks", cycles);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	task automatic report_failure(input string msg);
		$display("%s", msg);
		errors++;
		test_failed = 1'b1;
	endtask

	task automatic check_data(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
			report_failure($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic check_addr(input string name, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp)
			report_failure($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic check_region(input string name, input nes_bus_pkg::region_t got,
	                            input nes_bus_pkg::region_t exp);
		if (got !== exp)
			report_failure($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic finish_test(input string name);
		tests++;
		if (test_failed)
			failed_tests++;
		$display("test %0d %s: %s", tests, name, test_failed ? "failed" : "ok");
	endtask

	// Region by address bounds, $4018 and up is cartridge space again
	function automatic nes_bus_pkg::region_t region_of(input logic [15:0] addr);
		if (addr >= 16'h4000 && addr < 16'h4018)
			return nes_bus_pkg::REGION_IO;
		else if (addr >= 16'h2000 && addr < 16'h4000)
			return nes_bus_pkg::REGION_PPU;
		return nes_bus_pkg::REGION_PRG;
	endfunction

	// Byte the CPU should see, prev is the byte returned one cycle earlier
	function automatic logic [7:0] model_rdata(input logic [15:0] addr, input logic [4:0] j1,
	                                           input logic [4:0] j2, input logic [7:0] prev);
		if (region_of(addr) == nes_bus_pkg::REGION_PPU)
			return ~addr[7:0];
		if (region_of(addr) == nes_bus_pkg::REGION_PRG)
			return addr[7:0] ^ addr[15:8];
		if (addr == 16'h4015)
			return apu_status;
		if (addr == 16'h4016)
			return {prev[7:5], j1}; // Top bits float
		if (addr == 16'h4017)
			return {prev[7:5], j2};
		return prev; // Open bus
	endfunction

	task automatic add_entry(input logic [15:0] addr, input logic [7:0] wdata, input logic rnw,
	                         input logic [3:0] strobe);
		tab_req[n_tab]    = '{addr: addr, wdata: wdata, rnw: rnw};
		tab_joy1[n_tab]   = 5'($random(seed));
		tab_joy2[n_tab]   = 5'($random(seed));
		tab_strobe[n_tab] = strobe;
		tab_rdata[n_tab]  = model_rdata(addr, tab_joy1[n_tab], tab_joy2[n_tab], prev_rdata);
		prev_rdata        = tab_rdata[n_tab];
		n_tab++;
	endtask

	task automatic fill_table();
		add_entry(16'h0000, 8'h00, 1'b1, 4'b0001);
		add_entry(16'h8123, 8'h00, 1'b1, 4'b0001);
		add_entry(16'h6000, 8'h55, 1'b0, 4'b0010);
		add_entry(16'h2002, 8'h00, 1'b1, 4'b0100);
		add_entry(16'h2007, 8'h3c, 1'b0, 4'b1000);
		add_entry(16'h3fff, 8'h00, 1'b1, 4'b0100); // Top of the PPU mirrors
		add_entry(16'h4015, 8'h00, 1'b1, 4'b0000);
		add_entry(16'h4016, 8'h05, 1'b0, 4'b0000); // Pad strobe on
		add_entry(16'h4016, 8'h00, 1'b1, 4'b0000);
		add_entry(16'h4017, 8'h00, 1'b1, 4'b0000);
		add_entry(16'h4000, 8'h9f, 1'b0, 4'b0000); // Write only APU register
		add_entry(16'h4016, 8'h02, 1'b0, 4'b0000);
		add_entry(16'h4018, 8'h00, 1'b1, 4'b0001); // Just past the IO block
		add_entry(16'h1fff, 8'h00, 1'b1, 4'b0001);
		add_entry(16'hc0de, 8'h00, 1'b1, 4'b0001);
	endtask

	// One CPU cycle sampled on falling edges, returns 2 ns after the closing edge
	task automatic run_cpu_cycle();
		int         n_clk;
		int         n_ppu;
		logic [3:0] strobes;
		n_clk = 0;
		n_ppu = 0;
		strobe_cnt = '{0, 0, 0, 0};
		jclk_cnt = '{0, 0};
		do begin
			@(negedge clk);
			n_clk++;
			strobes = {ppu_write, ppu_read, prg_write, prg_read};
			for (int i = 0; i < 4; i++)
				strobe_cnt[i] += int'(strobes[i]);
			jclk_cnt[0] += int'(joypad_clock[0]);
			jclk_cnt[1] += int'(joypad_clock[1]);
			if (nes_dma_bus_i.phase.ppu_ce)
				n_ppu++;
			if (|strobes || cpu_ce) begin
				cyc_addr = mem_addr; // Bus is held for the whole cycle
				cyc_data = mem_wdata;
			end
		end while (!cpu_ce && n_clk < 2 * nes_bus_pkg::cpu_div);
		rd_at_ce    = cpu_rdata;
		pause_at_ce = pause_cpu;
		ack_at_ce   = dmc_ack;
		reg_at_ce   = nes_dma_bus_i.region;
		if (n_clk != nes_bus_pkg::cpu_div || n_ppu != 3)
			report_failure($sformatf("CPU cycle took %0d clocks with %0d ppu_ce pulses",
			                         n_clk, n_ppu));
		@(posedge clk);
		#2;
	endtask

	task automatic check_strobes(input logic [3:0] exp);
		for (int i = 0; i < 4; i++)
			if (strobe_cnt[i] != int'(exp[i]))
				report_failure($sformatf("%s pulsed %0d times in one CPU cycle, expected %0d",
				                         strobe_name[i], strobe_cnt[i], exp[i]));
	endtask

	// Page write to $4014, then the copy is followed cycle by cycle
	task automatic run_sprite_dma(input logic [7:0] page, input int steal_at);
		int         writes;
		int         acks;
		logic [7:0] lo;
		logic [7:0] held;
		logic       have_byte;
		writes    = 0;
		acks      = 0;
		lo        = 8'h00;
		held      = 8'h00;
		have_byte = 1'b0;
		test_failed = 1'b0;
		cpu = '{addr: 16'h4014, wdata: page, rnw: 1'b0};
		run_cpu_cycle();
		cpu = '{addr: 16'h4015, wdata: 8'h00, rnw: 1'b1}; // Held read, makes no strobe
		while (writes < 256) begin
			if (writes == steal_at && acks == 0)
				dmc_req = 1'b1;
			run_cpu_cycle();
			if (!pause_at_ce)
				report_failure($sformatf("pause_cpu low with %0d sprite writes done", writes));
			if (strobe_cnt[1] + strobe_cnt[2] != 0)
				report_failure("prg_write or ppu_read pulsed during sprite DMA");
			if (ack_at_ce) begin
				acks++;
				dmc_req = 1'b0;
				check_strobes(4'b0001);
				check_addr("mem_addr", cyc_addr, dmc_addr);
			end else if (strobe_cnt[0] == 1) begin
				if (have_byte)
					report_failure("sprite read came before the previous byte went to $2004");
				check_addr("mem_addr", cyc_addr, {page, lo});
				held      = page ^ lo; // Model value for P:lo
				have_byte = 1'b1;
			end else if (strobe_cnt[3] == 1) begin
				if (!have_byte)
					report_failure("ppu_write to $2004 came without a sprite read before it");
				check_addr("mem_addr", cyc_addr, nes_bus_pkg::oam_data_addr);
				check_data("mem_wdata", cyc_data, held);
				have_byte = 1'b0;
				lo++;
				writes++;
			end
		end
		run_cpu_cycle();
		if (pause_at_ce)
			report_failure("pause_cpu still high after the last sprite write");
		if (acks != 1)
			report_failure($sformatf("dmc_ack seen in %0d CPU cycles, expected 1", acks));
		finish_test($sformatf("sprite DMA page %h with DMC steal", page));
	endtask

	initial begin
		logic [1:0] jclk_exp;
		logic [2:0] joy_out_exp;
		seed         = 32'h839a_5e50;
		reset        = 1'b1;
		cpu          = '{addr: 16'h0000, wdata: 8'h00, rnw: 1'b1};
		dmc_req      = 1'b0;
		dmc_addr     = 16'hc123;
		apu_status   = 8'h4a;
		joypad1_data = '0;
		joypad2_data = '0;
		joy_out_exp  = 3'd0;
		fill_table();
		// Table cycles plus the whole sprite copy, with room for reset and idle cycles
		limit = (n_tab + 600) * nes_bus_pkg::cpu_div + 120;
		repeat (10) @(posedge clk);
		#2 reset = 1'b0;

		test_failed = 1'b0;
		repeat (4) run_cpu_cycle(); // Clock enables checked in every cycle
		check_data("joypad_out", {5'd0, joypad_out}, 8'h00);
		if (pause_at_ce || ack_at_ce)
			report_failure("pause_cpu or dmc_ack active after reset");
		finish_test("clock enables and reset values");

		for (int i = 0; i < n_tab; i++) begin
			test_failed  = 1'b0;
			cpu          = tab_req[i];
			joypad1_data = tab_joy1[i];
			joypad2_data = tab_joy2[i];
			run_cpu_cycle();
			check_strobes(tab_strobe[i]);
			check_addr("mem_addr", cyc_addr, tab_req[i].addr);
			if (!tab_req[i].rnw)
				check_data("mem_wdata", cyc_data, tab_req[i].wdata);
			check_region("region", reg_at_ce, region_of(tab_req[i].addr));
			check_data("cpu_rdata", rd_at_ce, tab_rdata[i]);
			jclk_exp = {tab_req[i].rnw && tab_req[i].addr == 16'h4017,
			            tab_req[i].rnw && tab_req[i].addr == 16'h4016};
			for (int b = 0; b < 2; b++)
				if (jclk_cnt[b] != int'(jclk_exp[b]))
					report_failure($sformatf("joypad_clock[%0d] pulsed %0d times, expected %0d",
					                         b, jclk_cnt[b], jclk_exp[b]));
			if (!tab_req[i].rnw && tab_req[i].addr == 16'h4016)
				joy_out_exp = tab_req[i].wdata[2:0];
			check_data("joypad_out", {5'd0, joypad_out}, {5'd0, joy_out_exp});
			finish_test($sformatf("%s %h", tab_req[i].rnw ? "read" : "write", tab_req[i].addr));
		end

		run_sprite_dma(8'h03, 100);

		$display("%0d tests run, %0d failed, %0d errors", tests, failed_tests, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== design/nes_dma_bus.sv ====
// ==============================
// NES bus and DMA core
// Clock divider, DMA mux, decoder and read return in one pipeline
// ==============================
`timescale 1ns/1ps

module nes_dma_bus (
	input  logic                             clk,
	input  logic                             reset,
	input  nes_bus_pkg::cpu_req_t            cpu,
	output logic                             cpu_ce,
	output logic [7:0]                       cpu_rdata,
	output logic                             pause_cpu,
	input  logic                             dmc_req,
	input  logic [15:0]                      dmc_addr,
	output logic                             dmc_ack,
	// Memory and PPU side
	output logic [15:0]                      mem_addr,
	output logic [7:0]                       mem_wdata,
	output logic                             prg_read,
	output logic                             prg_write,
	output logic                             ppu_read,
	output logic                             ppu_write,
	input  logic [7:0]                       prg_rdata,
	input  logic [7:0]                       ppu_rdata,
	input  logic [7:0]                       apu_status,
	// Joypads
	output logic [2:0]                       joypad_out,
	output logic [1:0]                       joypad_clock,
	input  logic [nes_bus_pkg::joy_bits-1:0] joypad1_data,
	input  logic [nes_bus_pkg::joy_bits-1:0] joypad2_data
);

	nes_bus_pkg::clk_phase_t phase;
	nes_bus_pkg::bus_cycle_t bus;
	nes_bus_pkg::region_t    region;

	assign cpu_ce = phase.cpu_ce;

	nes_clock_divider clock_divider_i (
		.clk   (clk),
		.reset (reset),
		.phase (phase)
	);

	oam_dmc_dma dma_i (
		.clk       (clk),
		.reset     (reset),
		.phase     (phase),
		.cpu       (cpu),
		.dmc_req   (dmc_req),
		.dmc_addr  (dmc_addr),
		.rdata     (cpu_rdata),   // Sprite latch fed from the returned byte
		.bus       (bus),
		.dmc_ack   (dmc_ack),
		.pause_cpu (pause_cpu)
	);

	nes_bus_decoder decoder_i (
		.clk          (clk),
		.reset        (reset),
		.phase        (phase),
		.bus          (bus),
		.region       (region),
		.mem_addr     (mem_addr),
		.mem_wdata    (mem_wdata),
		.prg_read     (prg_read),
		.prg_write    (prg_write),
		.ppu_read     (ppu_read),
		.ppu_write    (ppu_write),
		.joypad_out   (joypad_out),
		.joypad_clock (joypad_clock)
	);

	nes_read_return read_return_i (
		.clk          (clk),
		.reset        (reset),
		.bus          (bus),
		.region       (region),
		.prg_rdata    (prg_rdata),
		.ppu_rdata    (ppu_rdata),
		.apu_status   (apu_status),
		.joypad1_data (joypad1_data),
		.joypad2_data (joypad2_data),
		.rdata        (cpu_rdata)
	);

endmodule

// ==== design/nes_read_return.sv ====
// ==============================
// NES read data return
// Selects the byte for the CPU or DMA, falls back to open bus
// ==============================
`timescale 1ns/1ps

module nes_read_return (
	input  logic                                clk,
	input  logic                                reset,
	input  nes_bus_pkg::bus_cycle_t             bus,
	input  nes_bus_pkg::region_t                region,
	input  logic [7:0]                          prg_rdata,
	input  logic [7:0]                          ppu_rdata,
	input  logic [7:0]                          apu_status,
	input  logic [nes_bus_pkg::joy_bits-1:0]    joypad1_data,
	input  logic [nes_bus_pkg::joy_bits-1:0]    joypad2_data,
	output logic [7:0]                          rdata
);

	logic [7:0] open_bus; // Last value seen on the data bus

	always_ff @(posedge clk) begin
		open_bus <= rdata; // Samples every master clock
	end

	always_comb begin
		if (reset) begin
			rdata = 8'h00;
		end else begin
			case (region)
				nes_bus_pkg::REGION_PPU: rdata = ppu_rdata;
				nes_bus_pkg::REGION_PRG: rdata = prg_rdata;
				default: begin
					// Pads drive only the low bits, the rest floats
					if (bus.addr == nes_bus_pkg::joy1_addr)
						rdata = {open_bus[7:nes_bus_pkg::joy_bits], joypad1_data};
					else if (bus.addr == nes_bus_pkg::joy2_addr)
						rdata = {open_bus[7:nes_bus_pkg::joy_bits], joypad2_data};
					else if (bus.addr == nes_bus_pkg::apu_status_addr)
						rdata = apu_status;
					else
						rdata = open_bus; // Write only APU registers
				end
			endcase
		end
	end

endmodule

// ==== design/nes_bus_decoder.sv ====
// ==============================
// NES bus decoder
// Region decode, slot timed memory and PPU strobes, joypad port
// ==============================
`timescale 1ns/1ps

module nes_bus_decoder (
	input  logic                    clk,
	input  logic                    reset,
	input  nes_bus_pkg::clk_phase_t phase,
	input  nes_bus_pkg::bus_cycle_t bus,
	output nes_bus_pkg::region_t    region,
	output logic [15:0]             mem_addr,
	output logic [7:0]              mem_wdata,
	output logic                    prg_read,
	output logic                    prg_write,
	output logic                    ppu_read,
	output logic                    ppu_write,
	output logic [2:0]              joypad_out,   // Bit 0 strobes the pads
	output logic [1:0]              joypad_clock  // One bit per pad
);

	logic joy1_sel;
	logic joy2_sel;
	logic ppu_rd_slot; // Second PPU tick, the PPU needs one tick to turn data around

	// Internal RAM and the cartridge both answer on the PRG port
	always_comb begin
		if (bus.addr >= nes_bus_pkg::io_base && bus.addr < nes_bus_pkg::io_end)
			region = nes_bus_pkg::REGION_IO;
		else if (bus.addr >= nes_bus_pkg::ppu_base && bus.addr < nes_bus_pkg::io_base)
			region = nes_bus_pkg::REGION_PPU;
		else
			region = nes_bus_pkg::REGION_PRG;
	end

	assign mem_addr  = bus.addr;
	assign mem_wdata = bus.data;

	assign ppu_rd_slot = phase.ppu_ce && (phase.ppu_tick == 2'd1);

	// One pulse per CPU cycle, each on its own PPU tick
	assign prg_read  = (region == nes_bus_pkg::REGION_PRG) && bus.rnw && phase.cart_slot;
	assign prg_write = (region == nes_bus_pkg::REGION_PRG) && !bus.rnw && phase.cart_slot;
	assign ppu_read  = (region == nes_bus_pkg::REGION_PPU) && bus.rnw && ppu_rd_slot;
	assign ppu_write = (region == nes_bus_pkg::REGION_PPU) && !bus.rnw && phase.cart_slot;

	// Joypads sit inside the IO block
	assign joy1_sel = (bus.addr == nes_bus_pkg::joy1_addr);
	assign joy2_sel = (bus.addr == nes_bus_pkg::joy2_addr);

	assign joypad_clock = {phase.cpu_ce && bus.rnw && joy2_sel,
	                       phase.cpu_ce && bus.rnw && joy1_sel};

	always_ff @(posedge clk) begin
		if (reset)
			joypad_out <= 3'd0;
		else if (phase.cpu_ce && !bus.rnw && joy1_sel)
			joypad_out <= bus.data[2:0]; // Held until the next $4016 write
	end

endmodule

// ==== design/oam_dmc_dma.sv ====
// ==============================
// Sprite and DMC DMA controller
// OAM copy from $4014, DMC sample fetch and the CPU/DMA bus multiplexer
// ==============================
`timescale 1ns/1ps

module oam_dmc_dma (
	input  logic                    clk,
	input  logic                    reset,
	input  nes_bus_pkg::clk_phase_t phase,
	input  nes_bus_pkg::cpu_req_t   cpu,
	input  logic                    dmc_req,   // Sample fetch wanted by the APU
	input  logic [15:0]             dmc_addr,
	input  logic [7:0]              rdata,     // Returned byte, valid on cpu_ce
	output nes_bus_pkg::bus_cycle_t bus,
	output logic                    dmc_ack,
	output logic                    pause_cpu
);

	nes_bus_pkg::spr_state_t spr_state;
	nes_bus_pkg::dmc_state_t dmc_state;
	logic [15:0] spr_addr;   // Source address, page latched from the $4014 write
	logic [7:0]  spr_data;   // Byte read on the even cycle, written on the odd one
	logic [8:0]  spr_next;   // Low address byte plus one, carry marks the end
	logic        even_cycle;
	logic        dma_owns;
	logic        cpu_read;
	logic        spr_trigger;

	assign even_cycle = ~phase.odd_cycle;
	assign spr_next   = {1'b0, spr_addr[7:0]} + 9'd1;

	// Sprite DMA halts the CPU from trigger to last write; a DMC request halts it at once
	assign pause_cpu = (spr_state != nes_bus_pkg::SPR_IDLE) || dmc_req;
	assign dmc_ack   = (dmc_state == nes_bus_pkg::DMC_FETCH) && even_cycle;
	assign dma_owns  = dmc_ack || (spr_state == nes_bus_pkg::SPR_COPY);

	// A halted CPU only performs dummy reads of its held address
	assign cpu_read    = cpu.rnw || pause_cpu;
	assign spr_trigger = !dma_owns && !cpu_read && (cpu.addr == nes_bus_pkg::oam_dma_addr);

	always_ff @(posedge clk) begin
		if (reset) begin
			spr_state <= nes_bus_pkg::SPR_IDLE;
			dmc_state <= nes_bus_pkg::DMC_IDLE;
		end else if (phase.cpu_ce) begin
			// DMC is armed on an even cycle and reads on the next even one
			case (dmc_state)
				nes_bus_pkg::DMC_IDLE:
					if (dmc_req && cpu_read && even_cycle)
						dmc_state <= nes_bus_pkg::DMC_FETCH;
				nes_bus_pkg::DMC_FETCH:
					if (even_cycle)
						dmc_state <= nes_bus_pkg::DMC_IDLE;
				default: dmc_state <= nes_bus_pkg::DMC_IDLE;
			endcase

			if (spr_trigger) begin
				spr_state <= nes_bus_pkg::SPR_WAIT; // 1 or 2 cycles until an even read slot
			end else begin
				case (spr_state)
					nes_bus_pkg::SPR_WAIT:
						if (phase.odd_cycle)
							spr_state <= nes_bus_pkg::SPR_COPY;
					nes_bus_pkg::SPR_COPY:
						if (dmc_ack)
							spr_state <= nes_bus_pkg::SPR_WAIT; // Stolen read, odd cycle idles
						else if (phase.odd_cycle && spr_next[8])
							spr_state <= nes_bus_pkg::SPR_IDLE; // 256th write done
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (phase.cpu_ce) begin
			if (spr_trigger)
				spr_addr <= {cpu.wdata, 8'h00};
			else if (spr_state == nes_bus_pkg::SPR_COPY && phase.odd_cycle)
				spr_addr[7:0] <= spr_next[7:0]; // Step after each write
			if (spr_state == nes_bus_pkg::SPR_COPY && even_cycle && !dmc_ack)
				spr_data <= rdata; // Only a sprite read fills the latch
		end
	end

	always_comb begin
		if (dma_owns) begin
			if (dmc_ack)
				bus.addr = dmc_addr;
			else if (even_cycle)
				bus.addr = spr_addr;
			else
				bus.addr = nes_bus_pkg::oam_data_addr;
			bus.data     = spr_data;
			bus.rnw      = even_cycle; // Reads even, writes odd
			bus.from_dma = 1'b1;
		end else begin
			bus.addr     = cpu.addr;
			bus.data     = cpu.wdata;
			bus.rnw      = cpu_read;
			bus.from_dma = 1'b0;
		end
	end

endmodule

// ==== design/nes_clock_divider.sv ====
// ==============================
// NES master clock divider
// CPU and PPU clock enables, PPU tick phase and APU odd/even cycle
// ==============================
`timescale 1ns/1ps

module nes_clock_divider (
	input  logic                    clk,
	input  logic                    reset,
	output nes_bus_pkg::clk_phase_t phase
);

	// Cyc  123456789ABC
	// CPU  -----------C
	// PPU  ---P---P---P
	logic [3:0] cpu_cnt;
	logic [1:0] ppu_cnt;
	logic [1:0] ppu_tick;
	logic       odd_cycle;
	logic       cpu_ce;
	logic       ppu_ce;
	logic       cart_slot;

	assign cpu_ce    = (cpu_cnt == 4'(nes_bus_pkg::cpu_div - 1)); // Last master clock of CPU cycle
	assign ppu_ce    = (ppu_cnt == 2'(nes_bus_pkg::ppu_div - 1));
	assign cart_slot = ppu_ce && (ppu_tick == 2'd0); // Cart sees CPU data from here on

	always_ff @(posedge clk) begin
		if (reset) begin
			cpu_cnt   <= '0;
			ppu_cnt   <= '0;
			ppu_tick  <= '0;
			odd_cycle <= 1'b1; // First cycle out of reset counts as odd
		end else begin
			cpu_cnt <= cpu_ce ? 4'd0 : cpu_cnt + 4'd1;
			ppu_cnt <= ppu_ce ? 2'd0 : ppu_cnt + 2'd1;

			// Restart the tick count at each CPU cycle boundary,
			// cpu_ce shares its clock with the third ppu_ce
			if (cpu_ce)
				ppu_tick <= 2'd0;
			else if (ppu_ce)
				ppu_tick <= ppu_tick + 2'd1;

			if (cpu_ce)
				odd_cycle <= ~odd_cycle; // APU get/put alternation
		end
	end

	assign phase = '{
		cpu_ce:    cpu_ce,
		ppu_ce:    ppu_ce,
		ppu_tick:  ppu_tick,
		odd_cycle: odd_cycle,
		cart_slot: cart_slot
	};

endmodule

// ==== design/nes_bus_pkg.sv ====
// ==============================
// NES bus package
// Shared constants, bus cycle structs and state enums for the bus/DMA core
// ==============================
package nes_bus_pkg;

	// Master clock dividers
	localparam int cpu_div = 12; // Master clocks per CPU cycle
	localparam int ppu_div = 4;  // Master clocks per PPU cycle

	// Fixed register addresses
	localparam logic [15:0] oam_dma_addr    = 16'h4014; // Write starts sprite DMA
	localparam logic [15:0] oam_data_addr   = 16'h2004; // Sprite DMA destination
	localparam logic [15:0] joy1_addr       = 16'h4016;
	localparam logic [15:0] joy2_addr       = 16'h4017;
	localparam logic [15:0] apu_status_addr = 16'h4015;

	// Region bounds
	localparam logic [15:0] ppu_base = 16'h2000; // PPU registers, mirrored up to io_base
	localparam logic [15:0] io_base  = 16'h4000; // APU and joypad block
	localparam logic [15:0] io_end   = 16'h4018; // First address past the IO block

	localparam int joy_bits = 5; // Joypad data width, rest of the byte is open bus

	// Request as the CPU presents it, held for a whole CPU cycle
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  wdata;
		logic        rnw;   // 1 = read
	} cpu_req_t;

	// Bus cycle after CPU/DMA multiplexing
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  data;     // Write data
		logic        rnw;
		logic        from_dma; // DMA owns this cycle
	} bus_cycle_t;

	typedef enum logic [1:0] {REGION_PRG = 2'd0, REGION_PPU = 2'd1, REGION_IO = 2'd2} region_t;

	// Bit 0 set means the CPU is paused, bit 1 set means DMA owns the bus
	typedef enum logic [1:0] {SPR_IDLE = 2'b00, SPR_WAIT = 2'b01, SPR_COPY = 2'b11} spr_state_t;

	typedef enum logic {DMC_IDLE = 1'b0, DMC_FETCH = 1'b1} dmc_state_t;

	// Clock divider outputs shared by every stage
	typedef struct packed {
		logic       cpu_ce;
		logic       ppu_ce;
		logic [1:0] ppu_tick;  // PPU ticks seen since the last cpu_ce
		logic       odd_cycle;
		logic       cart_slot; // First PPU tick of the CPU cycle
	} clk_phase_t;

endpackage
